/* common/raycast_pkg.sv */
`default_nettype none

package raycast_pkg;

    // one 38 bit DDA result per screen column
    typedef struct packed {
        logic [8:0]  hcount;       // screen column
        logic [7:0]  line_height;  // unclamped wall height in rows
        logic        wall_side;    // 1 = y-side hit
        logic [3:0]  map_id;       // map cell that was hit
        logic [15:0] wall_x;       // texture coordinate carried but unused for colour
    } column_rec_t;

    typedef logic [15:0] pixel_t; // rgb565

    localparam pixel_t CEIL_COLOR  = 16'h4208; // dark grey
    localparam pixel_t FLOOR_COLOR = 16'h8410; // mid grey

    // wall palette indexed by map_id with entry 0 as empty space
    localparam pixel_t PALETTE [16] = '{
        16'h0000, // black
        16'hF800, // red
        16'h07E0, // green
        16'h001F, // blue
        16'hFFFF, // white
        16'hFFE0, // yellow
        16'h07FF, // cyan
        16'hF81F, // magenta
        16'hFD20, // orange
        16'hA145, // brown
        16'h8010, // purple
        16'h0410, // teal
        16'h8400, // olive
        16'h0010, // navy
        16'h8000, // maroon
        16'hFE19  // pink
    };

    // y-side walls are drawn darker so corners stand out
    function automatic pixel_t wall_color(input logic [3:0] map_id, input logic wall_side);
        pixel_t base;
        base = PALETTE[map_id];
        if (wall_side) begin
            // halve each channel on its own without borrow between fields
            return {1'b0, base[15:12], 1'b0, base[10:6], 1'b0, base[4:1]};
        end
        return base;
    endfunction

endpackage

`default_nettype wire

/* design/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                       clk_pixel,
    input  wire                       sys_rst,
    input  wire                       in_valid,
    input  wire raycast_pkg::column_rec_t in_data,
    input  wire                       in_last,
    output logic                      in_ready,
    output logic                      out_valid,
    output raycast_pkg::column_rec_t  out_data,
    output logic                      out_last,
    input  wire                       out_ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // record storage
    raycast_pkg::column_rec_t rec_mem [FIFO_DEPTH];
    logic                     last_mem [FIFO_DEPTH]; // frame end flag beside each record

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count; // occupancy

    logic push;
    logic pop;

    // full fifo still takes a word when one leaves in the same cycle
    assign in_ready  = (count != CNT_W'(FIFO_DEPTH)) || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = rec_mem[rd_ptr]; // head word falls through
    assign out_last  = last_mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk_pixel) begin
        if (push) begin
            rec_mem[wr_ptr]  <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // wrap by compare so depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* column_render/column_flattener.sv */
`timescale 1ns/1ps
`default_nettype none

module column_flattener #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240
) (
    input  wire                         clk_pixel,
    input  wire                         sys_rst,
    input  wire                         rec_valid,
    input  wire raycast_pkg::column_rec_t rec_data,
    input  wire                         rec_last,
    output logic                        rec_ready,
    output logic                        wr_en,
    output logic [$clog2(SCREEN_WIDTH*SCREEN_HEIGHT)-1:0] wr_addr,
    output raycast_pkg::pixel_t         wr_pixel,
    output logic                        wr_frame_last
);

    localparam int ADDR_W = $clog2(SCREEN_WIDTH * SCREEN_HEIGHT);
    localparam int ROW_W  = $clog2(SCREEN_HEIGHT);
    localparam int SPAN_W = $clog2(SCREEN_HEIGHT + 1); // must hold SCREEN_HEIGHT itself

    logic              busy;     // one record in flight
    logic [ROW_W-1:0]  row_cnt;
    logic              last_row;
    logic [ADDR_W-1:0] addr_r;   // row * width + column stepped per row

    // latched per record
    logic [SPAN_W-1:0]   top_row;
    logic [SPAN_W-1:0]   wall_end; // first floor row
    raycast_pkg::pixel_t wall_pix;
    logic                last_r;

    // span of the incoming record
    logic [SPAN_W-1:0] span_h;
    logic [SPAN_W-1:0] span_top;

    always_comb begin
        if (rec_data.line_height > SCREEN_HEIGHT) begin
            span_h = SPAN_W'(SCREEN_HEIGHT); // clamp tall walls
        end else begin
            span_h = SPAN_W'(rec_data.line_height);
        end
        span_top = (SPAN_W'(SCREEN_HEIGHT) - span_h) >> 1; // rounds down
    end

    assign rec_ready = !busy; // only take a record when idle
    assign last_row  = (row_cnt == ROW_W'(SCREEN_HEIGHT - 1));

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            busy    <= 1'b0;
            row_cnt <= '0;
        end else if (!busy) begin
            if (rec_valid) begin
                busy    <= 1'b1;
                row_cnt <= '0;
            end
        end else begin
            row_cnt <= row_cnt + 1'b1;
            if (last_row) begin
                busy <= 1'b0; // ready again next cycle
            end
        end
    end

    // record payload and address walk
    always_ff @(posedge clk_pixel) begin
        if (!busy && rec_valid) begin
            top_row  <= span_top;
            wall_end <= span_top + span_h;
            wall_pix <= raycast_pkg::wall_color(rec_data.map_id, rec_data.wall_side);
            last_r   <= rec_last;
            addr_r   <= ADDR_W'(rec_data.hcount); // row 0 of this column
        end else if (busy) begin
            addr_r <= addr_r + ADDR_W'(SCREEN_WIDTH); // next row down without a multiplier
        end
    end

    // one write per row while busy
    assign wr_en         = busy;
    assign wr_addr       = addr_r;
    assign wr_frame_last = busy && last_r && last_row; // final write of the frame

    always_comb begin
        if (SPAN_W'(row_cnt) < top_row) begin
            wr_pixel = raycast_pkg::CEIL_COLOR;
        end else if (SPAN_W'(row_cnt) < wall_end) begin
            wr_pixel = wall_pix;
        end else begin
            wr_pixel = raycast_pkg::FLOOR_COLOR;
        end
    end

endmodule

`default_nettype wire

/* column_render/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240
) (
    input  wire                  clk_pixel,
    input  wire                  sys_rst,
    input  wire                  wr_en,
    input  wire [$clog2(SCREEN_WIDTH*SCREEN_HEIGHT)-1:0] wr_addr,
    input  wire raycast_pkg::pixel_t wr_pixel,
    input  wire                  wr_frame_last,
    input  wire [10:0]           hcount,
    input  wire [9:0]            vcount,
    input  wire                  video_last_pixel,
    output raycast_pkg::pixel_t  rgb,
    output logic                 frame_swap
);

    localparam int NUM_PIX = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int ADDR_W  = $clog2(NUM_PIX);

    // two full frames with one drawn while the other is shown
    raycast_pkg::pixel_t buf0 [NUM_PIX];
    raycast_pkg::pixel_t buf1 [NUM_PIX];

    logic front_sel;   // which buffer the video side reads
    logic swap_pend;   // a finished frame waits for end of scan

    logic              in_screen;
    logic [ADDR_W-1:0] rd_addr;

    // read pipeline
    raycast_pkg::pixel_t rd_pix0;
    raycast_pkg::pixel_t rd_pix1;
    logic                rd_sel;
    logic                rd_valid;

    // writes always land in the back buffer
    always_ff @(posedge clk_pixel) begin
        if (wr_en && front_sel) begin
            buf0[wr_addr] <= wr_pixel;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (wr_en && !front_sel) begin
            buf1[wr_addr] <= wr_pixel;
        end
    end

    assign in_screen = (hcount < SCREEN_WIDTH) && (vcount < SCREEN_HEIGHT);

    always_comb begin
        if (in_screen) begin
            rd_addr = ADDR_W'(32'(vcount) * SCREEN_WIDTH + 32'(hcount));
        end else begin
            rd_addr = '0; // keep index in range during blanking
        end
    end

    // both arrays read every cycle and selected afterwards
    always_ff @(posedge clk_pixel) begin
        rd_pix0 <= buf0[rd_addr];
        rd_pix1 <= buf1[rd_addr];
        rd_sel  <= front_sel;
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= in_screen;
        end
    end

    // one cycle behind hcount/vcount and black off screen
    assign rgb = !rd_valid ? '0 : (rd_sel ? rd_pix1 : rd_pix0);

    // swap only at end of a video frame and never mid scan
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            front_sel  <= 1'b0;  // buffer 0 shown while buffer 1 is drawn first
            swap_pend  <= 1'b0;
            frame_swap <= 1'b0;
        end else begin
            frame_swap <= 1'b0;
            if (swap_pend && video_last_pixel) begin
                front_sel  <= !front_sel;
                swap_pend  <= 1'b0;
                frame_swap <= 1'b1;
            end
            // a new finished frame wins over the clear above
            if (wr_en && wr_frame_last) begin
                swap_pend <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/raycast_column_top.sv */
`timescale 1ns/1ps
`default_nettype none

module raycast_column_top #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240,
    parameter int FIFO_DEPTH    = 16
) (
    input  wire                         clk_pixel,
    input  wire                         sys_rst,
    // column records from the DDA
    input  wire                         col_valid,
    input  wire raycast_pkg::column_rec_t col_data,
    input  wire                         col_last,   // final column of a frame
    output logic                        col_ready,
    // video scan
    input  wire [10:0]                  hcount,
    input  wire [9:0]                   vcount,
    input  wire                         video_last_pixel,
    output raycast_pkg::pixel_t         rgb,
    output logic                        frame_swap
);

    localparam int ADDR_W = $clog2(SCREEN_WIDTH * SCREEN_HEIGHT);

    // fifo to flattener
    logic                     rec_valid;
    logic                     rec_ready;
    raycast_pkg::column_rec_t rec_data;
    logic                     rec_last;

    // flattener to frame buffer without back-pressure
    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr;
    raycast_pkg::pixel_t wr_pixel;
    logic                wr_frame_last;

    stream_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) stream_fifo_i (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .in_valid(col_valid),
        .in_data(col_data),
        .in_last(col_last),
        .in_ready(col_ready),
        .out_valid(rec_valid),
        .out_data(rec_data),
        .out_last(rec_last),
        .out_ready(rec_ready)
    );

    column_flattener #(
        .SCREEN_WIDTH(SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) column_flattener_i (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .rec_valid(rec_valid),
        .rec_data(rec_data),
        .rec_last(rec_last),
        .rec_ready(rec_ready),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_pixel(wr_pixel),
        .wr_frame_last(wr_frame_last)
    );

    frame_buffer #(
        .SCREEN_WIDTH(SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) frame_buffer_i (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_pixel(wr_pixel),
        .wr_frame_last(wr_frame_last),
        .hcount(hcount),
        .vcount(vcount),
        .video_last_pixel(video_last_pixel),
        .rgb(rgb),
        .frame_swap(frame_swap)
    );

endmodule

`default_nettype wire

/* dv/raycast_column_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module raycast_column_chk #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 240,
    parameter int FIFO_DEPTH    = 16
) (
    input wire                           clk_pixel,
    input wire                           sys_rst,
    input wire                           col_valid,
    input wire                           col_ready,
    input wire raycast_pkg::column_rec_t col_data,
    input wire                           col_last,
    input wire                           rec_valid,
    input wire                           rec_ready,
    input wire                           wr_en,
    input wire [$clog2(SCREEN_WIDTH*SCREEN_HEIGHT)-1:0] wr_addr,
    input wire                           frame_swap
);

    int unsigned fail_count = 0;
    int          occupancy; // fifo fill rebuilt from the two handshakes

    always @(posedge clk_pixel) begin
        if (sys_rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(col_valid && col_ready)
                                   - int'(rec_valid && rec_ready);
        end
    end

    // sender holds a stalled record
    hold_while_stalled: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        col_valid && !col_ready |=> col_valid && $stable(col_data) && $stable(col_last))
        else begin
            $error("column record changed or was withdrawn while col_ready was low");
            fail_count++;
        end

    swap_one_cycle: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        frame_swap |=> !frame_swap)
        else begin
            $error("frame_swap stayed high for two cycles");
            fail_count++;
        end

    addr_in_frame: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        wr_en |-> int'(wr_addr) < SCREEN_WIDTH * SCREEN_HEIGHT)
        else begin
            $error("write address beyond the frame");
            fail_count++;
        end

    fifo_not_over: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        occupancy <= FIFO_DEPTH)
        else begin
            $error("fifo holds more records than its depth");
            fail_count++;
        end

endmodule

`default_nettype wire

/* dv/raycast_column_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module raycast_column_tb;

    localparam int W      = 32;
    localparam int H      = 24;
    localparam int DEPTH  = 4;
    localparam int NPIX   = W * H;
    localparam int FRAMES = 2;
    // flatten every column plus one scan per frame and double it for slack
    localparam int LIMIT  = FRAMES * (W * (H + 1) + W * H) * 2 + 1000;

    logic                     clk_pixel;
    logic                     sys_rst;
    logic                     col_valid;
    raycast_pkg::column_rec_t col_data;
    logic                     col_last;
    logic                     col_ready;
    logic [10:0]              hcount;
    logic [9:0]               vcount;
    logic                     video_last_pixel;
    raycast_pkg::pixel_t      rgb;
    logic                     frame_swap;

    raycast_pkg::pixel_t      front_model [NPIX]; // frame the video side should show
    raycast_pkg::pixel_t      back_model [NPIX];  // frame being drawn
    raycast_pkg::column_rec_t recs [W];

    int cycle_count  = 0;
    int swap_count   = 0;
    int stall_cycles = 0; // negedges with col_valid high and col_ready low
    int tests_run    = 0;
    int tests_failed = 0;
    int errors       = 0;

    raycast_column_top #(
        .SCREEN_WIDTH(W),
        .SCREEN_HEIGHT(H),
        .FIFO_DEPTH(DEPTH)
    ) raycast_column_top_i (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .col_valid(col_valid),
        .col_data(col_data),
        .col_last(col_last),
        .col_ready(col_ready),
        .hcount(hcount),
        .vcount(vcount),
        .video_last_pixel(video_last_pixel),
        .rgb(rgb),
        .frame_swap(frame_swap)
    );

    bind raycast_column_top raycast_column_chk #(
        .SCREEN_WIDTH(SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) raycast_column_chk_i (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .col_valid(col_valid),
        .col_ready(col_ready),
        .col_data(col_data),
        .col_last(col_last),
        .rec_valid(rec_valid),
        .rec_ready(rec_ready),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .frame_swap(frame_swap)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #10 clk_pixel = ~clk_pixel;
    end

    always @(negedge clk_pixel) begin
        if (frame_swap === 1'b1) swap_count++; // sampled mid cycle where the pulse is stable
    end

    always @(posedge clk_pixel) begin
        cycle_count++;
        if (cycle_count > LIMIT) begin
            $display("timeout: run still going after %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic raycast_pkg::pixel_t expected_wall(input logic [3:0] map_id,
                                                          input logic side);
        raycast_pkg::pixel_t base;
        base = raycast_pkg::PALETTE[map_id];
        if (!side) return base;
        return {base[15:11] >> 1, base[10:5] >> 1, base[4:0] >> 1}; // each channel halved
    endfunction

    // one column of the back model with the span centred and clamped
    task automatic draw_column(input raycast_pkg::column_rec_t rec);
        int h;
        int top;
        h   = (rec.line_height > H) ? H : int'(rec.line_height);
        top = (H - h) / 2;
        for (int r = 0; r < H; r++) begin
            if (r < top) back_model[r * W + rec.hcount] = raycast_pkg::CEIL_COLOR;
            else if (r < top + h) back_model[r * W + rec.hcount] =
                expected_wall(rec.map_id, rec.wall_side);
            else back_model[r * W + rec.hcount] = raycast_pkg::FLOOR_COLOR;
        end
    endtask

    task automatic make_frame(input bit with_clamp);
        logic [7:0] lh;
        for (int c = 0; c < W; c++) begin
            lh = 8'($urandom_range(0, 30)); // some above H clamp too
            if (with_clamp && c == 0) lh = 8'd0;
            if (with_clamp && c == 1) lh = 8'd24;
            if (with_clamp && c == 2) lh = 8'd200;
            recs[c].hcount      = 9'(c);
            recs[c].line_height = lh;
            recs[c].wall_side   = 1'($urandom_range(0, 1));
            recs[c].map_id      = 4'($urandom_range(0, 15));
            recs[c].wall_x      = 16'($urandom);
            draw_column(recs[c]);
        end
    endtask

    // called at edge + 2 ns and returns at edge + 2 ns after the transfer
    task automatic send_column(input int c, input logic last);
        col_valid = 1'b1;
        col_data  = recs[c];
        col_last  = last;
        @(negedge clk_pixel);
        while (col_ready !== 1'b1) begin
            stall_cycles++;
            @(negedge clk_pixel);
        end
        @(posedge clk_pixel);
        #2;
    endtask

    task automatic scan_frame(input bit check, input string name, input int clamp_cols,
                              output int errs, output int clamp_errs);
        int    prev;
        string who;
        errs       = 0;
        clamp_errs = 0;
        prev       = -1;
        for (int p = 0; p <= NPIX; p++) begin
            @(posedge clk_pixel);
            #2;
            if (check && prev >= 0) begin // rgb holds the position driven one cycle back
                who = (prev % W < clamp_cols) ? "clamping" : name;
                assert (rgb === front_model[prev]) else begin
                    $display("ERR %s: pixel x=%0d y=%0d expected %h actual %h",
                             who, prev % W, prev / W, front_model[prev], rgb);
                    if (prev % W < clamp_cols) clamp_errs++;
                    else errs++;
                end
            end
            if (p < NPIX) begin
                hcount           = 11'(p % W);
                vcount           = 10'(p / W);
                video_last_pixel = (p == NPIX - 1);
            end else begin
                hcount           = 11'(W); // park off screen
                vcount           = '0;
                video_last_pixel = 1'b0;
            end
            prev = (p < NPIX) ? p : -1;
        end
        @(posedge clk_pixel);
        #2;
        if (check) begin
            assert (rgb === '0) else begin
                $display("ERR %s: off-screen rgb expected 0000 actual %h", name, rgb);
                errs++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (errs != 0) tests_failed++;
        errors += errs;
        $display("test %-14s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    initial begin
        int e_main;
        int e_clamp;
        int e_swap;
        int e_extra;
        int swaps_before;
        int chk_fails;
        void'($urandom(32'hfd552453));
        sys_rst          = 1'b1;
        col_valid        = 1'b0;
        col_data         = '0;
        col_last         = 1'b0;
        hcount           = 11'(W);
        vcount           = '0;
        video_last_pixel = 1'b0;
        repeat (4) @(posedge clk_pixel);
        #2;
        sys_rst = 1'b0;
        @(posedge clk_pixel);
        #2;

        e_extra = 0;
        assert (col_ready === 1'b1 && frame_swap === 1'b0) else begin
            $display("reset_state: col_ready not high or frame_swap not low after reset");
            e_extra++;
        end
        finish_test("reset_state", e_extra);

        // frame 1 back to back while the flattener spends 25 cycles per record
        make_frame(1'b1);
        for (int c = 0; c < W; c++) send_column(c, c == W - 1);
        col_valid = 1'b0;
        col_last  = 1'b0;
        swaps_before = swap_count;
        scan_frame(1'b0, "back_pressure", 0, e_main, e_clamp); // front still unwritten
        e_extra = 0;
        assert (swap_count == swaps_before + 1) else begin
            $display("back_pressure: frame 1 did not swap at the end of the first scan");
            e_extra++;
        end
        assert (stall_cycles > 0) else begin
            $display("back_pressure: col_ready never dropped during back to back records");
            e_extra++;
        end
        front_model = back_model;
        scan_frame(1'b1, "column_split", 3, e_main, e_clamp);
        finish_test("column_split", e_main);
        finish_test("clamping", e_clamp);
        finish_test("back_pressure", e_extra);

        // frame 2 minus its last column keeps the old frame on screen
        make_frame(1'b0);
        for (int c = 0; c < W - 1; c++) send_column(c, 1'b0);
        col_valid = 1'b0;
        swaps_before = swap_count;
        scan_frame(1'b1, "swap_timing", 0, e_swap, e_clamp);
        assert (swap_count == swaps_before) else begin
            $display("swap_timing: frame_swap pulsed before the frame's final write");
            e_swap++;
        end
        send_column(W - 1, 1'b1);
        col_valid = 1'b0;
        col_last  = 1'b0;
        scan_frame(1'b0, "swap_timing", 0, e_main, e_clamp); // ends well after the last write
        assert (swap_count == swaps_before + 1) else begin
            $display("swap_timing: expected one frame_swap at the first scan end, saw %0d",
                     swap_count - swaps_before);
            e_swap++;
        end
        finish_test("swap_timing", e_swap);
        front_model = back_model;
        scan_frame(1'b1, "second_frame", 0, e_main, e_clamp);
        finish_test("second_frame", e_main);

        chk_fails = int'(raycast_column_top_i.raycast_column_chk_i.fail_count);
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/raycast_pkg.sv
design/stream_fifo.sv
column_render/column_flattener.sv
column_render/frame_buffer.sv
design/raycast_column_top.sv
dv/raycast_column_chk.sv
dv/raycast_column_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module raycast_column_tb -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/sim" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0
